// ==== dv/keypad_lock_tb.sv ====
module keypad_lock_tb;

    // about 300 presses of 6 cycles plus the lockouts and one long tone with wide margin
    localparam int MAX_CYCLES = 60_000;

    logic                  clk;
    logic                  rst_n;
    logic                  psel;
    logic                  penable;
    logic                  pwrite;
    lock_pkg::addr_t       paddr;
    logic [31:0]           pwdata;
    logic [31:0]           prdata;
    logic                  pready;
    logic                  pslverr;
    logic [15:0]           onehot;
    lock_pkg::code_t       entry;
    logic [1:0]            digit_count;
    logic                  unlocked;
    logic                  lockout;
    logic                  buzzer;
    int                    cycles = 0;

    lock_pkg::code_t       m_secret;  // reference model
    lock_pkg::code_t       m_entry;
    int                    m_count;
    int                    m_tries;
    int                    m_max;
    lock_pkg::lock_state_t m_state;

    keypad_lock DUT (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            stop_run($sformatf("timeout: the run went past %0d cycles", MAX_CYCLES));
        end
    end

    task automatic stop_run(input string msg);
        $display("%s", msg);
        $display("=== FAIL ===");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            stop_run($sformatf("error: %s is 0x%0h, expected 0x%0h", name, got, exp));
        end
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #10;  // drive point
    endtask

    task automatic apb_read(input lock_pkg::addr_t addr, output logic [31:0] data,
                            output logic err);
        psel    = 1'b1;
        pwrite  = 1'b0;
        paddr   = addr;
        next_cycle();
        penable = 1'b1;
        #20;  // read data settles early in the access phase
        data    = prdata;
        err     = pslverr;
        check_value("pready", 32'(pready), 32'd1);
        next_cycle();
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic apb_write(input lock_pkg::addr_t addr, input logic [31:0] data);
        psel    = 1'b1;
        pwrite  = 1'b1;
        paddr   = addr;
        pwdata  = data;
        next_cycle();
        penable = 1'b1;
        #20;
        check_value("pready", 32'(pready), 32'd1);
        check_value("pslverr", 32'(pslverr), 32'd0);
        next_cycle();
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic expect_read(input lock_pkg::addr_t addr, input string name,
                               input logic [31:0] exp);
        logic [31:0] rd;
        logic        err;
        apb_read(addr, rd, err);
        check_value("pslverr", 32'(err), 32'd0);
        check_value(name, rd, exp);
    endtask

    function automatic void model_key(input int k);
        case (m_state)
            lock_pkg::ENTRY, lock_pkg::PROGRAM: begin
                if (k < 10 && m_count < 3) begin
                    m_entry = {m_entry[7:0], 4'(k)};
                    m_count++;
                end else if (k == int'(lock_pkg::KEY_CLEAR)) begin
                    m_entry = '0;
                    m_count = 0;
                    if (m_state == lock_pkg::PROGRAM) m_state = lock_pkg::OPEN;
                end else if (k == int'(lock_pkg::KEY_ENTER) && m_count == 3) begin
                    if (m_state == lock_pkg::PROGRAM) begin
                        m_secret = m_entry;  // new code stored
                        m_state  = lock_pkg::OPEN;
                    end else if (m_entry == m_secret) begin
                        m_state = lock_pkg::OPEN;
                        m_tries = 0;
                    end else begin
                        m_tries++;
                        if (m_tries >= m_max) m_state = lock_pkg::LOCKOUT;
                    end
                    m_entry = '0;
                    m_count = 0;
                end
            end
            lock_pkg::OPEN: begin
                if (k == int'(lock_pkg::KEY_CLEAR)) begin
                    m_state = lock_pkg::ENTRY;
                end else if (k == int'(lock_pkg::KEY_PROG)) begin
                    m_state = lock_pkg::PROGRAM;
                end
            end
            default: ;  // lockout drops every key
        endcase
    endfunction

    task automatic check_outputs();
        check_value("entry", 32'(entry), 32'(m_entry));
        check_value("digit_count", 32'(digit_count), 32'(m_count));
        check_value("unlocked", 32'(unlocked), 32'(m_state == lock_pkg::OPEN ||
                                                    m_state == lock_pkg::PROGRAM));
        check_value("lockout", 32'(lockout), 32'(m_state == lock_pkg::LOCKOUT));
    endtask

    // hold for 2 cycles and release for 4 so the outputs settle
    task automatic press_lines(input logic [15:0] lines);
        onehot = lines;
        repeat (2) next_cycle();
        onehot = '0;
        repeat (4) next_cycle();
    endtask

    task automatic press_key(input int k);
        press_lines(16'h1 << k);
        model_key(k);
        check_outputs();
    endtask

    task automatic type_digits(input lock_pkg::code_t code);
        press_key(int'(code[11:8]));
        press_key(int'(code[7:4]));
        press_key(int'(code[3:0]));
    endtask

    task automatic enter_code(input lock_pkg::code_t code);
        logic [31:0] rd;
        logic        err;
        type_digits(code);
        press_key(int'(lock_pkg::KEY_ENTER));
        apb_read(lock_pkg::ADDR_STATUS, rd, err);
        check_value("status.tries", 32'(rd[7:4]), 32'(m_tries));
        check_value("status.state", 32'(rd[1:0]), 32'(m_state));
    endtask

    task automatic wait_lockout_end();
        int waited;
        waited = 0;
        while (lockout && waited < 60) begin  // 3 s of 10 cycles plus slack
            next_cycle();
            waited++;
        end
        if (lockout) stop_run("lockout did not end within 60 cycles");
        m_state = lock_pkg::ENTRY;
        m_tries = 0;
        m_entry = '0;
        m_count = 0;
        expect_read(lock_pkg::ADDR_STATUS, "status after lockout", 32'h0);
    endtask

    task automatic try_code(input lock_pkg::code_t code);
        enter_code(code);
        if (m_state == lock_pkg::LOCKOUT) wait_lockout_end();
    endtask

    function automatic lock_pkg::code_t random_code();
        lock_pkg::code_t c;
        c[11:8] = 4'($urandom % 10);
        c[7:4]  = 4'($urandom % 10);
        c[3:0]  = 4'($urandom % 10);
        return c;
    endfunction

    function automatic lock_pkg::code_t wrong_code();
        lock_pkg::code_t c;
        c      = m_secret;
        c[3:0] = (c[3:0] == 4'd9) ? 4'd0 : c[3:0] + 4'd1;
        return c;
    endfunction

    initial begin
        logic [31:0]     rd;
        logic [31:0]     rd2;
        logic            err;
        logic            prev_bz;
        lock_pkg::code_t code;
        lock_pkg::code_t old_code;
        int              last;
        int              toggles;
        void'($urandom(24));
        rst_n    = 1'b0;
        psel     = 1'b0;
        penable  = 1'b0;
        pwrite   = 1'b0;
        paddr    = '0;
        pwdata   = '0;
        onehot   = '0;
        m_secret = 12'h246;
        m_entry  = '0;
        m_count  = 0;
        m_tries  = 0;
        m_max    = 3;
        m_state  = lock_pkg::ENTRY;
        repeat (16) @(posedge clk);
        #10;
        rst_n = 1'b1;
        next_cycle();

        // register defaults and an unmapped read
        check_outputs();
        check_value("buzzer", 32'(buzzer), 32'd0);
        expect_read(lock_pkg::ADDR_MAX_TRIES, "max_tries", 32'd3);
        expect_read(lock_pkg::ADDR_LOCK_SECS, "lock_secs", 32'd60);
        expect_read(lock_pkg::ADDR_TICK_DIV, "tick_div", 32'd49_999_999);
        expect_read(lock_pkg::ADDR_SECRET, "secret", 32'd0);
        expect_read(lock_pkg::ADDR_STATUS, "status", 32'd0);
        apb_read(5'h14, rd, err);
        check_value("pslverr", 32'(err), 32'd1);

        // random codes with roughly a third correct
        apb_write(lock_pkg::ADDR_TICK_DIV, 32'd9);
        apb_write(lock_pkg::ADDR_LOCK_SECS, 32'd3);
        for (int i = 0; i < 40; i++) begin
            code = ($urandom % 3 == 0) ? m_secret : random_code();
            try_code(code);
            if (m_state == lock_pkg::OPEN) press_key(int'(lock_pkg::KEY_CLEAR));
        end

        // lockout after max_tries wrong codes in a row
        try_code(m_secret);  // tries back to zero
        press_key(int'(lock_pkg::KEY_CLEAR));
        m_max = 1 + int'($urandom % 4);
        apb_write(lock_pkg::ADDR_MAX_TRIES, 32'(m_max));
        for (int i = 0; i < m_max; i++) begin
            enter_code(wrong_code());
        end
        press_key(5);  // dropped while locked out
        apb_read(lock_pkg::ADDR_STATUS, rd, err);
        repeat (8) next_cycle();
        apb_read(lock_pkg::ADDR_STATUS, rd2, err);
        if (rd[15:8] == 8'd0 || rd2[15:8] >= rd[15:8]) begin
            stop_run("remaining seconds did not count down during the lockout");
        end
        wait_lockout_end();
        m_max = 3;
        apb_write(lock_pkg::ADDR_MAX_TRIES, 32'd3);

        // new secret from the keypad and then from the bus
        old_code = m_secret;
        try_code(m_secret);
        press_key(int'(lock_pkg::KEY_PROG));
        code = random_code();
        type_digits(code);
        press_key(int'(lock_pkg::KEY_ENTER));
        press_key(int'(lock_pkg::KEY_CLEAR));
        try_code(code);
        check_value("unlocked", 32'(unlocked), 32'd1);
        press_key(int'(lock_pkg::KEY_CLEAR));
        try_code(old_code);  // fails unless the draw repeated it
        old_code = m_secret;
        code     = random_code();
        apb_write(lock_pkg::ADDR_SECRET, 32'(code));
        m_secret = code;
        try_code(code);
        check_value("unlocked", 32'(unlocked), 32'd1);
        press_key(int'(lock_pkg::KEY_CLEAR));
        try_code(old_code);

        // patterns that must not register
        press_lines(16'h0003);
        check_outputs();
        press_lines(16'h2000);
        check_outputs();
        press_lines(16'h8001);  // digit 0 with an unused line
        check_outputs();
        type_digits(wrong_code());
        press_key(7);  // fourth digit
        press_key(int'(lock_pkg::KEY_CLEAR));
        press_key(1);
        press_key(2);
        press_key(int'(lock_pkg::KEY_ENTER));  // short entry
        press_key(int'(lock_pkg::KEY_CLEAR));

        // success tone with cycles counted from the rise of unlocked
        type_digits(m_secret);
        press_key(int'(lock_pkg::KEY_ENTER));
        check_value("unlocked", 32'(unlocked), 32'd1);
        prev_bz = buzzer;
        last    = -1;
        toggles = 0;
        for (int i = 4; i <= int'(lock_pkg::OK_LEN) + 10; i++) begin
            next_cycle();
            if (buzzer != prev_bz) begin
                if (last >= 0) begin
                    check_value("buzzer half period", 32'(i - last),
                                32'(lock_pkg::OK_HALF));
                end
                last    = i;
                prev_bz = buzzer;
                toggles++;
            end
        end
        if (toggles < 10) stop_run("buzzer did not toggle after a correct code");
        check_value("buzzer", 32'(buzzer), 32'd0);

        $display("=== PASS ===");
        $finish;
    end

endmodule

// ==== keypad_lock.f ====
rtl/lock_pkg.sv
rtl/keypad_decoder.sv
rtl/lock_ctrl.sv
rtl/lockout_timer.sv
rtl/buzzer_tone.sv
rtl/lock_regs.sv
rtl/keypad_lock.sv
dv/keypad_lock_tb.sv

// ==== rtl/buzzer_tone.sv ====
module buzzer_tone (
    input  logic clk,
    input  logic rst_n,
    input  logic ev_key,
    input  logic ev_ok,
    input  logic ev_fail,
    output logic buzzer
);

    lock_pkg::tone_t half_lim;  // last count of a half period
    lock_pkg::tone_t len_lim;   // last count of the tone
    lock_pkg::tone_t half_cnt;
    lock_pkg::tone_t dur_cnt;
    logic            active;
    logic            any_ev;

    assign any_ev = ev_key || ev_ok || ev_fail;

    // latest event picks the tone
    always_ff @(posedge clk) begin
        if (ev_ok) begin
            half_lim <= lock_pkg::OK_HALF - 1'b1;
            len_lim  <= lock_pkg::OK_LEN - 1'b1;
        end else if (ev_fail) begin
            half_lim <= lock_pkg::FAIL_HALF - 1'b1;
            len_lim  <= lock_pkg::FAIL_LEN - 1'b1;
        end else if (ev_key) begin
            half_lim <= lock_pkg::KEY_HALF - 1'b1;
            len_lim  <= lock_pkg::KEY_LEN - 1'b1;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            active   <= 1'b0;
            buzzer   <= 1'b0;
            half_cnt <= '0;
            dur_cnt  <= '0;
        end else if (any_ev) begin  // restart from the top
            active   <= 1'b1;
            buzzer   <= 1'b1;
            half_cnt <= '0;
            dur_cnt  <= '0;
        end else if (active) begin
            if (dur_cnt == len_lim) begin
                active <= 1'b0;
                buzzer <= 1'b0;  // tone over, rest low
            end else begin
                dur_cnt <= dur_cnt + 1'b1;
                if (half_cnt == half_lim) begin
                    half_cnt <= '0;
                    buzzer   <= ~buzzer;
                end else begin
                    half_cnt <= half_cnt + 1'b1;
                end
            end
        end
    end

endmodule

// ==== rtl/keypad_decoder.sv ====
module keypad_decoder (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic [lock_pkg::KEY_LINES-1:0]  onehot,
    output logic                            key_valid,
    output lock_pkg::key_t                  key_code
);

    logic [lock_pkg::KEY_LINES-1:0] onehot_q;  // sampled keypad lines
    logic [lock_pkg::KEY_LINES-1:0] onehot_d;  // previous sample
    logic [lock_pkg::NUM_KEYS-1:0]  mapped;
    logic                           single_hot;
    logic                           press;
    lock_pkg::key_t                 code_nxt;

    assign mapped     = onehot_q[lock_pkg::NUM_KEYS-1:0];
    assign single_hot = (mapped != '0) && ((mapped & (mapped - 1'b1)) == '0);
    // rising from idle to one legal key, nothing on 13-15
    assign press      = (onehot_d == '0) && single_hot &&
                        (onehot_q[lock_pkg::KEY_LINES-1:lock_pkg::NUM_KEYS] == '0);

    always_comb begin
        code_nxt = '0;
        for (int i = 0; i < lock_pkg::NUM_KEYS; i++) begin
            if (mapped[i]) begin
                code_nxt = 4'(i);  // bit index is the key code
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            onehot_q  <= '0;
            onehot_d  <= '0;
            key_valid <= 1'b0;
        end else begin
            onehot_q  <= onehot;
            onehot_d  <= onehot_q;
            key_valid <= press;
        end
    end

    always_ff @(posedge clk) begin
        if (press) begin
            key_code <= code_nxt;
        end
    end

    // a press needs a return to idle before the next one
    assert property (@(posedge clk) disable iff (!rst_n) key_valid |=> !key_valid);

endmodule

// ==== rtl/keypad_lock.sv ====
module keypad_lock (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           psel,
    input  logic                           penable,
    input  logic                           pwrite,
    input  lock_pkg::addr_t                paddr,
    input  logic [31:0]                    pwdata,
    output logic [31:0]                    prdata,
    output logic                           pready,
    output logic                           pslverr,
    input  logic [lock_pkg::KEY_LINES-1:0] onehot,
    output lock_pkg::code_t                entry,
    output logic [1:0]                     digit_count,
    output logic                           unlocked,
    output logic                           lockout,
    output logic                           buzzer
);

    logic                  key_valid;
    lock_pkg::key_t        key_code;
    lock_pkg::code_t       secret;
    lock_pkg::code_t       new_secret;
    lock_pkg::try_t        max_tries;
    lock_pkg::try_t        tries;
    lock_pkg::secs_t       lock_secs;
    lock_pkg::secs_t       remaining;
    lock_pkg::div_t        tick_div;
    lock_pkg::lock_state_t state;
    logic                  secret_wr;
    logic                  lock_start;
    logic                  lock_done;
    logic                  ev_key;
    logic                  ev_ok;
    logic                  ev_fail;

    keypad_decoder u_dec (
        .clk, .rst_n, .onehot, .key_valid, .key_code
    );

    lock_ctrl u_ctrl (
        .clk, .rst_n, .key_valid, .key_code, .secret, .max_tries, .lock_done,
        .entry, .digit_count, .unlocked, .lockout, .tries, .state,
        .lock_start, .secret_wr, .new_secret, .ev_key, .ev_ok, .ev_fail
    );

    lockout_timer u_timer (
        .clk, .rst_n, .lock_start, .lock_secs, .tick_div, .remaining, .lock_done
    );

    buzzer_tone u_buzz (
        .clk, .rst_n, .ev_key, .ev_ok, .ev_fail, .buzzer
    );

    lock_regs u_regs (
        .clk, .rst_n, .psel, .penable, .pwrite, .paddr, .pwdata, .prdata,
        .pready, .pslverr, .secret_wr, .new_secret, .state, .tries, .remaining,
        .secret, .max_tries, .lock_secs, .tick_div
    );

endmodule

// ==== rtl/lock_ctrl.sv ====
module lock_ctrl (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  key_valid,
    input  lock_pkg::key_t        key_code,
    input  lock_pkg::code_t       secret,
    input  lock_pkg::try_t        max_tries,
    input  logic                  lock_done,
    output lock_pkg::code_t       entry,
    output logic [1:0]            digit_count,
    output logic                  unlocked,
    output logic                  lockout,
    output lock_pkg::try_t        tries,
    output lock_pkg::lock_state_t state,
    output logic                  lock_start,
    output logic                  secret_wr,
    output lock_pkg::code_t       new_secret,
    output logic                  ev_key,
    output logic                  ev_ok,
    output logic                  ev_fail
);

    logic           is_digit;
    logic           is_enter;
    logic           is_clear;
    logic           is_prog;
    logic           buf_full;
    logic           store;
    lock_pkg::try_t tries_inc;

    assign is_digit  = key_valid && (key_code < lock_pkg::KEY_ENTER);
    assign is_enter  = key_valid && (key_code == lock_pkg::KEY_ENTER);
    assign is_clear  = key_valid && (key_code == lock_pkg::KEY_CLEAR);
    assign is_prog   = key_valid && (key_code == lock_pkg::KEY_PROG);
    assign buf_full  = (digit_count == 2'(lock_pkg::CODE_DIGITS));
    assign store     = (state == lock_pkg::PROGRAM) && is_enter && buf_full;
    assign tries_inc = tries + 1'b1;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state       <= lock_pkg::ENTRY;
            entry       <= '0;
            digit_count <= '0;
            unlocked    <= 1'b0;
            lockout     <= 1'b0;
            tries       <= '0;
            lock_start  <= 1'b0;
            secret_wr   <= 1'b0;
            ev_key      <= 1'b0;
            ev_ok       <= 1'b0;
            ev_fail     <= 1'b0;
        end else begin
            lock_start <= 1'b0;
            secret_wr  <= 1'b0;
            ev_key     <= 1'b0;
            ev_ok      <= 1'b0;
            ev_fail    <= 1'b0;

            // extra digits past the third are dropped
            if (is_digit && !buf_full &&
                (state == lock_pkg::ENTRY || state == lock_pkg::PROGRAM)) begin
                entry       <= {entry[7:0], key_code};
                digit_count <= digit_count + 1'b1;
                ev_key      <= 1'b1;
            end

            case (state)
                lock_pkg::ENTRY: begin
                    if (is_clear) begin
                        entry       <= '0;
                        digit_count <= '0;
                    end else if (is_enter && buf_full) begin
                        entry       <= '0;
                        digit_count <= '0;
                        if (entry == secret) begin
                            state    <= lock_pkg::OPEN;
                            unlocked <= 1'b1;
                            tries    <= '0;
                            ev_ok    <= 1'b1;
                        end else begin
                            tries   <= tries_inc;
                            ev_fail <= 1'b1;
                            if (tries_inc >= max_tries) begin  // out of tries
                                state      <= lock_pkg::LOCKOUT;
                                lockout    <= 1'b1;
                                lock_start <= 1'b1;
                            end
                        end
                    end
                end
                lock_pkg::OPEN: begin
                    if (is_clear) begin  // relock
                        state       <= lock_pkg::ENTRY;
                        unlocked    <= 1'b0;
                        entry       <= '0;
                        digit_count <= '0;
                    end else if (is_prog) begin
                        state <= lock_pkg::PROGRAM;
                    end
                end
                lock_pkg::PROGRAM: begin
                    if (is_clear) begin  // abandon, keep old secret
                        state       <= lock_pkg::OPEN;
                        entry       <= '0;
                        digit_count <= '0;
                    end else if (store) begin
                        state       <= lock_pkg::OPEN;
                        secret_wr   <= 1'b1;
                        ev_ok       <= 1'b1;
                        entry       <= '0;
                        digit_count <= '0;
                    end
                end
                default: begin  // lockout, keys ignored
                    if (lock_done) begin
                        state       <= lock_pkg::ENTRY;
                        lockout     <= 1'b0;
                        tries       <= '0;
                        entry       <= '0;
                        digit_count <= '0;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (store) begin
            new_secret <= entry;
        end
    end

    assert property (@(posedge clk) disable iff (!rst_n) !(unlocked && lockout));
    // limit comes from the register block
    assert property (@(posedge clk) disable iff (!rst_n) tries <= max_tries);

endmodule

// ==== rtl/lock_pkg.sv ====
package lock_pkg;

    localparam int CODE_DIGITS = 3;
    localparam int KEY_LINES   = 16;
    localparam int NUM_KEYS    = 13;  // digits 0-9, enter, clear, program
    localparam int TONE_W      = 12;

    typedef logic [3:0]                               digit_t;
    typedef logic [$bits(digit_t)*CODE_DIGITS-1:0]    code_t;  // msd first
    typedef logic [3:0]                               key_t;
    typedef logic [3:0]                               try_t;
    typedef logic [7:0]                               secs_t;
    typedef logic [25:0]                              div_t;  // one second at 50 MHz fits
    typedef logic [4:0]                               addr_t;
    typedef logic [TONE_W-1:0]                        tone_t;

    typedef enum logic [1:0] {
        ENTRY   = 2'd0,
        OPEN    = 2'd1,
        PROGRAM = 2'd2,
        LOCKOUT = 2'd3
    } lock_state_t;

    localparam key_t KEY_ENTER = 4'd10;
    localparam key_t KEY_CLEAR = 4'd11;
    localparam key_t KEY_PROG  = 4'd12;

    localparam addr_t ADDR_SECRET    = 5'h00;
    localparam addr_t ADDR_MAX_TRIES = 5'h04;
    localparam addr_t ADDR_LOCK_SECS = 5'h08;
    localparam addr_t ADDR_TICK_DIV  = 5'h0C;
    localparam addr_t ADDR_STATUS    = 5'h10;

    localparam code_t RST_SECRET    = 12'h246;
    localparam try_t  RST_MAX_TRIES = 4'd3;
    localparam secs_t RST_LOCK_SECS = 8'd60;
    localparam div_t  RST_TICK_DIV  = 26'd49_999_999;

    // half periods and lengths in clock cycles
    localparam tone_t KEY_HALF  = 12'd50;
    localparam tone_t KEY_LEN   = 12'd1000;
    localparam tone_t OK_HALF   = 12'd25;
    localparam tone_t OK_LEN    = 12'd3000;
    localparam tone_t FAIL_HALF = 12'd100;
    localparam tone_t FAIL_LEN  = 12'd1500;

endpackage

// ==== rtl/lock_regs.sv ====
module lock_regs (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  psel,
    input  logic                  penable,
    input  logic                  pwrite,
    input  lock_pkg::addr_t       paddr,
    input  logic [31:0]           pwdata,
    output logic [31:0]           prdata,
    output logic                  pready,
    output logic                  pslverr,
    input  logic                  secret_wr,
    input  lock_pkg::code_t       new_secret,
    input  lock_pkg::lock_state_t state,
    input  lock_pkg::try_t        tries,
    input  lock_pkg::secs_t       remaining,
    output lock_pkg::code_t       secret,
    output lock_pkg::try_t        max_tries,
    output lock_pkg::secs_t       lock_secs,
    output lock_pkg::div_t        tick_div
);

    logic        wr_en;
    logic        addr_hit;
    logic [31:0] status_word;

    assign pready      = 1'b1;  // zero wait states
    assign wr_en       = psel && penable && pwrite;
    assign status_word = {16'h0, remaining, tries, 2'b00, state};

    always_comb begin
        prdata   = '0;
        addr_hit = 1'b1;
        case (paddr)
            lock_pkg::ADDR_SECRET:    prdata = '0;  // never read back
            lock_pkg::ADDR_MAX_TRIES: prdata = {28'h0, max_tries};
            lock_pkg::ADDR_LOCK_SECS: prdata = {24'h0, lock_secs};
            lock_pkg::ADDR_TICK_DIV:  prdata = {6'h0, tick_div};
            lock_pkg::ADDR_STATUS:    prdata = status_word;
            default:                  addr_hit = 1'b0;
        endcase
    end

    // unmapped, or a write to the read-only status
    assign pslverr = psel && penable &&
                     (!addr_hit || (pwrite && paddr == lock_pkg::ADDR_STATUS));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            secret    <= lock_pkg::RST_SECRET;
            max_tries <= lock_pkg::RST_MAX_TRIES;
            lock_secs <= lock_pkg::RST_LOCK_SECS;
            tick_div  <= lock_pkg::RST_TICK_DIV;
        end else begin
            if (secret_wr) begin  // keypad beats the bus
                secret <= new_secret;
            end else if (wr_en && paddr == lock_pkg::ADDR_SECRET) begin
                secret <= pwdata[11:0];
            end
            if (wr_en && paddr == lock_pkg::ADDR_MAX_TRIES) begin
                max_tries <= pwdata[3:0];
            end
            if (wr_en && paddr == lock_pkg::ADDR_LOCK_SECS) begin
                lock_secs <= pwdata[7:0];
            end
            if (wr_en && paddr == lock_pkg::ADDR_TICK_DIV) begin
                tick_div <= pwdata[25:0];
            end
        end
    end

    // error only in an access phase that followed its setup phase
    assert property (@(posedge clk) disable iff (!rst_n)
        pslverr |-> (penable && $past(psel && !penable)));

endmodule

// ==== rtl/lockout_timer.sv ====
module lockout_timer (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            lock_start,
    input  lock_pkg::secs_t lock_secs,
    input  lock_pkg::div_t  tick_div,
    output lock_pkg::secs_t remaining,
    output logic            lock_done
);

    lock_pkg::div_t presc;   // cycles within the current second
    logic           active;
    logic           tick;

    assign tick = active && (presc == tick_div);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            presc     <= '0;
            active    <= 1'b0;
            remaining <= '0;
            lock_done <= 1'b0;
        end else begin
            lock_done <= 1'b0;
            if (lock_start) begin  // (re)load the countdown
                presc     <= '0;
                remaining <= lock_secs;
                active    <= 1'b1;
            end else if (tick) begin
                presc <= '0;
                if (remaining <= 8'd1) begin  // last second gone
                    remaining <= '0;
                    active    <= 1'b0;
                    lock_done <= 1'b1;
                end else begin
                    remaining <= remaining - 1'b1;
                end
            end else if (active) begin
                presc <= presc + 1'b1;
            end
        end
    end

    assert property (@(posedge clk) disable iff (!rst_n) lock_done |-> (remaining == '0));

endmodule

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the keypad lock testbench with Verilator.
set -u
cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing --assert -Wno-fatal \
    -f keypad_lock.f --top-module keypad_lock_tb \
    -Mdir "$OBJ" -o keypad_lock_sim
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

"./$OBJ/keypad_lock_sim" > "$LOG" 2>&1
run_status=$?
cat "$LOG"

if grep -q "=== FAIL ===" "$LOG"; then
    echo "simulation reported failure"
    exit 1
fi
if [ $run_status -ne 0 ]; then
    echo "simulation exited with status $run_status"
    exit 1
fi
exit 0
